/* verilog/ray_gen_pkg.sv */
`default_nettype none

package ray_gen_pkg;

	// screen geometry.
	localparam int RAY_COLS = 8;
	localparam int RAY_ROWS = 6;
	localparam int NUM_RAYS = RAY_COLS * RAY_ROWS;

	// datapath widths.
	localparam int COORD_W = 16;
	localparam int PIX_W   = 6;
	localparam int X_W     = 3;
	localparam int Y_W     = 3;

	// output queue and pipeline.
	localparam int FIFO_DEPTH = 8;
	localparam int CNT_W      = 4;
	localparam int PIPE_LAT   = 3;

endpackage : ray_gen_pkg

`default_nettype wire

/* verilog/ray_scan_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module ray_scan_fsm (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        start,
	input  logic                                        pixel_last,
	input  logic [$clog2(ray_gen_pkg::PIPE_LAT+1)-1:0]  in_flight,
	input  logic [ray_gen_pkg::CNT_W-1:0]               used,
	input  logic                                        fifo_empty,
	output logic                                        issue,
	output logic                                        busy,
	output logic                                        done
);
	import ray_gen_pkg::*;

	enum logic [1:0] {IDLE, ACTIVE, DRAIN} state, state_n;

	logic [CNT_W:0] credit_sum;
	logic           has_credit;
	logic           drained;

	// ############################################################
	// credit check.
	// ############################################################

	// rays in the pipe will all land in the queue, so count them too.
	assign credit_sum = {1'b0, used} + {{(CNT_W - 1){1'b0}}, in_flight};
	assign has_credit = (credit_sum < FIFO_DEPTH);
	assign drained    = fifo_empty && (in_flight == '0);

	assign issue = (state == ACTIVE) && has_credit;
	assign busy  = (state != IDLE);

	// ############################################################
	// frame state.
	// ############################################################

	always_comb begin
		state_n = state;
		case (state)
			IDLE: begin
				if (start)
					state_n = ACTIVE;
			end
			ACTIVE: begin
				if (issue && pixel_last)
					state_n = DRAIN;
			end
			DRAIN: begin
				if (drained)
					state_n = IDLE;
			end
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_n;
			// one pulse, lands as busy falls.
			done  <= (state == DRAIN) && drained;
		end
	end

endmodule : ray_scan_fsm

`default_nettype wire

/* verilog/pixel_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_counter (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            step,
	output logic [ray_gen_pkg::X_W-1:0]     x,
	output logic [ray_gen_pkg::Y_W-1:0]     y,
	output logic [ray_gen_pkg::PIX_W-1:0]   pixel,
	output logic                            pixel_last
);
	import ray_gen_pkg::*;

	logic row_end;

	assign row_end    = (x == X_W'(RAY_COLS - 1));
	assign pixel_last = (pixel == PIX_W'(NUM_RAYS - 1));

	// scan starts at the top row, y counts down.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x     <= '0;
			y     <= Y_W'(RAY_ROWS - 1);
			pixel <= '0;
		end else if (step) begin
			if (pixel_last) begin
				// back to the frame origin for the next start.
				x     <= '0;
				y     <= Y_W'(RAY_ROWS - 1);
				pixel <= '0;
			end else begin
				pixel <= pixel + 1'b1;
				if (row_end) begin
					x <= '0;
					y <= y - 1'b1;
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

endmodule : pixel_counter

`default_nettype wire

/* verilog/ray_dir_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module ray_dir_pipe (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        in_valid,
	input  logic [ray_gen_pkg::X_W-1:0]                 x,
	input  logic [ray_gen_pkg::Y_W-1:0]                 y,
	input  logic [ray_gen_pkg::PIX_W-1:0]               pixel_in,
	input  logic [ray_gen_pkg::COORD_W-1:0]             u_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]             u_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]             u_z,
	input  logic [ray_gen_pkg::COORD_W-1:0]             v_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]             v_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]             v_z,
	input  logic [ray_gen_pkg::COORD_W-1:0]             w_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]             w_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]             w_z,
	output logic                                        out_valid,
	output logic [ray_gen_pkg::PIX_W-1:0]               pixel_out,
	output logic [ray_gen_pkg::COORD_W-1:0]             dir_x,
	output logic [ray_gen_pkg::COORD_W-1:0]             dir_y,
	output logic [ray_gen_pkg::COORD_W-1:0]             dir_z,
	output logic [$clog2(ray_gen_pkg::PIPE_LAT+1)-1:0]  in_flight
);
	import ray_gen_pkg::*;

	logic signed [COORD_W-1:0] sx_d, sy_d;
	logic signed [COORD_W-1:0] s1_sx, s1_sy;
	logic [PIX_W-1:0]          s1_pix, s2_pix;
	logic                      s1_v, s2_v;
	logic [COORD_W-1:0]        s2_ux, s2_uy, s2_uz;
	logic [COORD_W-1:0]        s2_vx, s2_vy, s2_vz;

	// centre the screen on the view axis.
	assign sx_d = COORD_W'(x) - COORD_W'(RAY_COLS / 2);
	assign sy_d = COORD_W'(y) - COORD_W'(RAY_ROWS / 2);

	// ############################################################
	// valid chain, never stalls.
	// ############################################################

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_v      <= 1'b0;
			s2_v      <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_v      <= in_valid;
			s2_v      <= s1_v;
			out_valid <= s2_v;
		end
	end

	assign in_flight = {1'b0, s1_v} + {1'b0, s2_v} + {1'b0, out_valid};

	// ############################################################
	// datapath, all arithmetic wraps at 16 bits.
	// ############################################################

	always_ff @(posedge clk) begin
		// stage 1.
		s1_sx  <= sx_d;
		s1_sy  <= sy_d;
		s1_pix <= pixel_in;
		// stage 2, low half of each product.
		s2_ux  <= s1_sx * u_x;
		s2_uy  <= s1_sx * u_y;
		s2_uz  <= s1_sx * u_z;
		s2_vx  <= s1_sy * v_x;
		s2_vy  <= s1_sy * v_y;
		s2_vz  <= s1_sy * v_z;
		s2_pix <= s1_pix;
		// stage 3.
		dir_x     <= w_x + s2_ux + s2_vx;
		dir_y     <= w_y + s2_uy + s2_vy;
		dir_z     <= w_z + s2_uz + s2_vz;
		pixel_out <= s2_pix;
	end

endmodule : ray_dir_pipe

`default_nettype wire

/* verilog/ray_out_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ray_out_fifo (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                wr,
	input  logic [ray_gen_pkg::PIX_W-1:0]       wr_pixel,
	input  logic [ray_gen_pkg::COORD_W-1:0]     wr_dir_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]     wr_dir_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]     wr_dir_z,
	input  logic                                stall,
	output logic                                valid,
	output logic [ray_gen_pkg::PIX_W-1:0]       rd_pixel,
	output logic [ray_gen_pkg::COORD_W-1:0]     rd_dir_x,
	output logic [ray_gen_pkg::COORD_W-1:0]     rd_dir_y,
	output logic [ray_gen_pkg::COORD_W-1:0]     rd_dir_z,
	output logic [ray_gen_pkg::CNT_W-1:0]       used,
	output logic                                empty
);
	import ray_gen_pkg::*;

	logic [PIX_W-1:0]   pix_mem [FIFO_DEPTH];
	logic [COORD_W-1:0] dx_mem  [FIFO_DEPTH];
	logic [COORD_W-1:0] dy_mem  [FIFO_DEPTH];
	logic [COORD_W-1:0] dz_mem  [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr, wr_ptr;
	logic                          pop;

	assign empty = (used == '0);
	assign valid = !empty;
	assign pop   = valid && !stall;

	// head entry shows ahead.
	assign rd_pixel = pix_mem[rd_ptr];
	assign rd_dir_x = dx_mem[rd_ptr];
	assign rd_dir_y = dy_mem[rd_ptr];
	assign rd_dir_z = dz_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr) begin
			pix_mem[wr_ptr] <= wr_pixel;
			dx_mem[wr_ptr]  <= wr_dir_x;
			dy_mem[wr_ptr]  <= wr_dir_y;
			dz_mem[wr_ptr]  <= wr_dir_z;
		end
	end

	// pointers wrap naturally, depth is a power of two.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			used   <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr && !pop)
				used <= used + 1'b1;
			else if (pop && !wr)
				used <= used - 1'b1;
		end
	end

endmodule : ray_out_fifo

`default_nettype wire

/* verilog/ray_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module ray_gen (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                start,
	input  logic [ray_gen_pkg::COORD_W-1:0]     u_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]     u_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]     u_z,
	input  logic [ray_gen_pkg::COORD_W-1:0]     v_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]     v_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]     v_z,
	input  logic [ray_gen_pkg::COORD_W-1:0]     w_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]     w_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]     w_z,
	input  logic                                ray_stall,
	output logic                                ray_valid,
	output logic [ray_gen_pkg::PIX_W-1:0]       ray_pixel,
	output logic [ray_gen_pkg::COORD_W-1:0]     ray_dir_x,
	output logic [ray_gen_pkg::COORD_W-1:0]     ray_dir_y,
	output logic [ray_gen_pkg::COORD_W-1:0]     ray_dir_z,
	output logic                                busy,
	output logic                                done
);
	import ray_gen_pkg::*;

	logic                              issue;
	logic                              pixel_last;
	logic [X_W-1:0]                    x;
	logic [Y_W-1:0]                    y;
	logic [PIX_W-1:0]                  pixel;
	logic [$clog2(PIPE_LAT+1)-1:0]     in_flight;
	logic                              out_valid;
	logic [PIX_W-1:0]                  pipe_pixel;
	logic [COORD_W-1:0]                pipe_dir_x, pipe_dir_y, pipe_dir_z;
	logic [CNT_W-1:0]                  used;
	logic                              fifo_empty;

	ray_scan_fsm i_fsm (
		.clk, .rst, .start, .pixel_last, .in_flight, .used, .fifo_empty,
		.issue, .busy, .done
	);

	pixel_counter i_pix (
		.clk, .rst, .step(issue), .x, .y, .pixel, .pixel_last
	);

	ray_dir_pipe i_pipe (
		.clk, .rst,
		.in_valid(issue), .x, .y, .pixel_in(pixel),
		.u_x, .u_y, .u_z, .v_x, .v_y, .v_z, .w_x, .w_y, .w_z,
		.out_valid, .pixel_out(pipe_pixel),
		.dir_x(pipe_dir_x), .dir_y(pipe_dir_y), .dir_z(pipe_dir_z),
		.in_flight
	);

	// queue absorbs shader back-pressure.
	ray_out_fifo i_fifo (
		.clk, .rst,
		.wr(out_valid), .wr_pixel(pipe_pixel),
		.wr_dir_x(pipe_dir_x), .wr_dir_y(pipe_dir_y), .wr_dir_z(pipe_dir_z),
		.stall(ray_stall),
		.valid(ray_valid), .rd_pixel(ray_pixel),
		.rd_dir_x(ray_dir_x), .rd_dir_y(ray_dir_y), .rd_dir_z(ray_dir_z),
		.used, .empty(fifo_empty)
	);

endmodule : ray_gen

`default_nettype wire

/* sim/ray_gen_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module ray_gen_assert (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                ray_valid,
	input  logic                                ray_stall,
	input  logic [ray_gen_pkg::PIX_W-1:0]       ray_pixel,
	input  logic [ray_gen_pkg::COORD_W-1:0]     ray_dir_x,
	input  logic [ray_gen_pkg::COORD_W-1:0]     ray_dir_y,
	input  logic [ray_gen_pkg::COORD_W-1:0]     ray_dir_z,
	input  logic                                done,
	input  logic                                out_valid,
	input  logic [ray_gen_pkg::CNT_W-1:0]       used
);
	import ray_gen_pkg::*;

	// a stalled ray stays put.
	property stall_hold;
		@(posedge clk) disable iff (rst)
		ray_valid && ray_stall |=> ray_valid && $stable(ray_pixel)
			&& $stable(ray_dir_x) && $stable(ray_dir_y) && $stable(ray_dir_z);
	endproperty

	a_stall_hold: assert property (stall_hold)
		else $error("ray output changed while stalled");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done high for more than one cycle");

	// credit must keep writes away from a full queue.
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!(out_valid && (used == CNT_W'(FIFO_DEPTH))))
		else $error("queue written while full");

endmodule : ray_gen_assert

bind ray_gen ray_gen_assert i_assert (
	.clk(clk), .rst(rst), .ray_valid(ray_valid), .ray_stall(ray_stall),
	.ray_pixel(ray_pixel), .ray_dir_x(ray_dir_x), .ray_dir_y(ray_dir_y),
	.ray_dir_z(ray_dir_z), .done(done), .out_valid(out_valid), .used(used)
);

`default_nettype wire

/* sim/tb_ray_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ray_gen;

	localparam int MAX_CASES       = 16;
	localparam int CYCLES_PER_CASE = 200;
	localparam int RESET_CYCLES    = 5;
	localparam int RAYS            = 48;

	logic        clk;
	logic        rst;
	logic        start;
	logic [15:0] u_x, u_y, u_z, v_x, v_y, v_z, w_x, w_y, w_z;
	logic        ray_stall;
	logic        ray_valid;
	logic [5:0]  ray_pixel;
	logic [15:0] ray_dir_x, ray_dir_y, ray_dir_z;
	logic        busy;
	logic        done;

	string       case_name [MAX_CASES];
	int          case_mode [MAX_CASES];
	logic [15:0] case_vec  [MAX_CASES][12];
	int          n_cases;
	string       cur_name;
	logic [31:0] lfsr_state;

	ray_gen i_dut (
		.clk, .rst, .start,
		.u_x, .u_y, .u_z, .v_x, .v_y, .v_z, .w_x, .w_y, .w_z,
		.ray_stall, .ray_valid, .ray_pixel, .ray_dir_x, .ray_dir_y, .ray_dir_z,
		.busy, .done
	);

	always #5 clk = ~clk;

	// ############################################################
	// reference model and helpers.
	// ############################################################

	// rows run from y = 5 down, x from 0 up; screen centred at (4, 3).
	function automatic logic [15:0] ref_dir(input int pix, input logic [15:0] u,
		input logic [15:0] v, input logic [15:0] w);
		int sx;
		int sy;
		sx = (pix % 8) - 4;
		sy = (5 - pix / 8) - 3;
		return 16'(int'(w) + sx * int'(u) + sy * int'(v));
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("mismatch %s %s expected %0h actual %0h", cur_name, what, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic load_cases();
		int          fd;
		int          n;
		int          k;
		int          md;
		string       line;
		string       nm;
		logic [15:0] t [12];
		fd = $fopen("sim/ray_gen_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file sim/ray_gen_cases.txt");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
		while (!$feof(fd) && n_cases < MAX_CASES) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h", nm, md,
					t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9], t[10], t[11]);
				if (n != 14) begin
					$display("malformed line in the case file: %s", line);
					$display("Simulation finished: FAIL");
					$fatal(1);
				end
				case_name[n_cases] = nm;
				case_mode[n_cases] = md;
				for (k = 0; k < 12; k++)
					case_vec[n_cases][k] = t[k];
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	// ############################################################
	// one frame.
	// ############################################################

	task automatic run_frame(input int c);
		int          got;
		logic        was_held;
		logic [63:0] held;
		got      = 0;
		was_held = 1'b0;
		held     = '0;
		cur_name = case_name[c];
		@(posedge clk);
		u_x   <= case_vec[c][0];
		u_y   <= case_vec[c][1];
		u_z   <= case_vec[c][2];
		v_x   <= case_vec[c][3];
		v_y   <= case_vec[c][4];
		v_z   <= case_vec[c][5];
		w_x   <= case_vec[c][6];
		w_y   <= case_vec[c][7];
		w_z   <= case_vec[c][8];
		start <= 1'b1;
		while (got < RAYS) begin
			@(posedge clk);
			// a second start mid frame.
			start <= (got == 10);
			if (case_mode[c] == 1) begin
				ray_stall  <= lfsr_state[0];
				lfsr_state = lfsr_next(lfsr_state);
			end else begin
				ray_stall <= 1'b0;
			end
			@(negedge clk);
			check("busy during frame", 1, busy);
			check("done before last ray", 0, done);
			if (was_held)
				check("ray held under stall", held,
					{ray_valid, ray_pixel, ray_dir_x, ray_dir_y, ray_dir_z});
			if (ray_valid && !ray_stall) begin
				check("pixel order", got, ray_pixel);
				check("dir_x", ref_dir(got, case_vec[c][0], case_vec[c][3], case_vec[c][6]),
					ray_dir_x);
				check("dir_y", ref_dir(got, case_vec[c][1], case_vec[c][4], case_vec[c][7]),
					ray_dir_y);
				check("dir_z", ref_dir(got, case_vec[c][2], case_vec[c][5], case_vec[c][8]),
					ray_dir_z);
				if (got == 0)
					check("pixel 0 from file",
						{case_vec[c][9], case_vec[c][10], case_vec[c][11]},
						{ray_dir_x, ray_dir_y, ray_dir_z});
				got++;
			end
			was_held = ray_valid && ray_stall;
			held     = {ray_valid, ray_pixel, ray_dir_x, ray_dir_y, ray_dir_z};
		end
		// done follows once queue and pipe are empty.
		do begin
			@(posedge clk);
			start     <= 1'b0;
			ray_stall <= 1'b0;
			@(negedge clk);
			check("valid after last ray", 0, ray_valid);
			check("busy drops with done", !done, busy);
		end while (!done);
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			check("idle after done {done,busy,valid}", 0, {done, busy, ray_valid});
		end
	endtask

	// ############################################################
	// main sequence and watchdog.
	// ############################################################

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		start      = 1'b0;
		ray_stall  = 1'b0;
		{u_x, u_y, u_z, v_x, v_y, v_z, w_x, w_y, w_z} = '0;
		lfsr_state = 32'he70b;
		n_cases    = 0;
		cur_name   = "reset";
		load_cases();
		if (n_cases == 0) begin
			$display("no cases found in the case file");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (2) begin
			@(negedge clk);
			check("idle after reset {valid,busy,done}", 0, {ray_valid, busy, done});
		end
		for (int c = 0; c < n_cases; c++)
			run_frame(c);
		$display("Simulation finished: PASS");
		$finish;
	end

	initial begin
		wait (n_cases > 0);
		#((RESET_CYCLES + n_cases * CYCLES_PER_CASE) * 10);
		$display("run timed out before all frames finished");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

endmodule : tb_ray_gen

`default_nettype wire

/* ray_gen.f */
verilog/ray_gen_pkg.sv
verilog/ray_scan_fsm.sv
verilog/pixel_counter.sv
verilog/ray_dir_pipe.sv
verilog/ray_out_fifo.sv
verilog/ray_gen.sv
sim/ray_gen_assert.sv
sim/tb_ray_gen.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ray_gen \
		-f ray_gen.f -o sim_ray_gen
	./obj_dir/sim_ray_gen | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/ray_gen_cases.txt */
# name stall_mode u_x u_y u_z v_x v_y v_z w_x w_y w_z pixel0_x pixel0_y pixel0_z
# stall_mode 0 never stalls, 1 stalls from the lfsr; vectors and pixel 0 direction in hex
axis_basic   0 0001 0000 0000 0000 0001 0000 0000 0000 0100 fffc 0002 0100
scaled_stall 1 0010 0002 0000 0001 0020 0003 1000 0800 7fff 0fc2 0838 8005
wrap_stall   1 ffff 8000 1234 7fff 0001 fedc 0000 ffff 0000 0002 0001 b4e8
small_steps  0 0003 0005 0007 0002 0004 0006 0010 0020 0030 0008 0014 0020
